// File: lsu_cfg_pkg.sv
package lsu_cfg_pkg;

    // load queue
    localparam int LDQ_DEPTH = 4;
    localparam int LDQ_IDX   = $clog2(LDQ_DEPTH);

    // store queue, pointers carry a wrap bit
    localparam int STQ_DEPTH = 4;
    localparam int STQ_IDX   = $clog2(STQ_DEPTH) + 1;

    localparam int ROB_ID_W  = 5;
    localparam int RD_W      = 6;   // physical dest reg

    localparam int XLEN      = 32;  // data and address

endpackage

// File: mem_op_pkg.sv
package mem_op_pkg;

    // bit 3 store, bit 2 unsigned load, bits 1:0 size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_op_t;

    function automatic logic is_store(input logic [3:0] op);
        return op[3];
    endfunction

    // byte lanes touched, from size and low address bits
    function automatic logic [3:0] byte_sel(input logic [3:0] op, input logic [1:0] off);
        case (op[1:0])
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << {off[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

endpackage

// File: load_queue.sv
`timescale 1ns/100ps

module load_queue
    import lsu_cfg_pkg::*;
    import mem_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    input  logic                 disp_valid,
    input  logic [3:0]           disp_op,
    input  logic [ROB_ID_W-1:0]  disp_rob_id,
    input  logic [RD_W-1:0]      disp_rd,
    output logic                 ldq_ready,

    input  logic                 agu_valid,
    input  logic [ROB_ID_W-1:0]  agu_rob_id,
    input  logic [XLEN-1:0]      agu_addr,

    input  logic [STQ_IDX-1:0]   stq_tail,
    input  logic                 stq_deq,
    input  logic [LDQ_DEPTH-1:0] has_conflict,
    output logic [STQ_IDX-1:0]   ldq_tracker [LDQ_DEPTH],
    output logic [XLEN-1:0]      ldq_addr    [LDQ_DEPTH],

    output logic                 ld_req,
    output logic [XLEN-1:0]      ld_addr,
    output logic [3:0]           ld_sel,
    output logic                 ld_kill,
    input  logic                 ld_gnt,
    input  logic                 ld_resp,
    input  logic [XLEN-1:0]      ld_rdata,

    output logic                 res_valid,
    output logic [ROB_ID_W-1:0]  res_rob_id,
    output logic [RD_W-1:0]      res_rd,
    output logic [XLEN-1:0]      res_value
);
    logic [LDQ_DEPTH-1:0] lq_valid;
    logic [LDQ_DEPTH-1:0] lq_addr_valid;
    mem_op_t              lq_op     [LDQ_DEPTH];
    logic [ROB_ID_W-1:0]  lq_rob_id [LDQ_DEPTH];
    logic [RD_W-1:0]      lq_rd     [LDQ_DEPTH];
    logic [LDQ_DEPTH-1:0] valid_nxt;

    logic                 push_en;
    logic [LDQ_IDX-1:0]   push_idx;
    logic                 issue_en;
    logic [LDQ_IDX-1:0]   issue_idx;

    logic                 in_flight;
    logic                 kill;
    mem_op_t              rsp_op;
    logic [1:0]           rsp_off;

    always_comb begin
        push_en  = 1'b0;
        push_idx = '0;
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < LDQ_DEPTH; i++) begin
            if (!push_en && !lq_valid[i]) begin   // lowest free slot
                push_en  = 1'b1;
                push_idx = LDQ_IDX'(i);
            end
            if (!issue_en && lq_valid[i] && lq_addr_valid[i] &&
                (ldq_tracker[i] == '0 || !has_conflict[i])) begin
                issue_en  = 1'b1;
                issue_idx = LDQ_IDX'(i);
            end
        end
        push_en = push_en && disp_valid && ldq_ready && !is_store(disp_op) && !flush;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            lq_valid <= '0;
        end else begin
            for (int i = 0; i < LDQ_DEPTH; i++) begin
                if (stq_deq && ldq_tracker[i] != '0) begin
                    ldq_tracker[i] <= ldq_tracker[i] - 1'b1;
                end
                if (agu_valid && lq_valid[i] && lq_rob_id[i] == agu_rob_id) begin
                    lq_addr_valid[i] <= 1'b1;
                    ldq_addr[i]      <= agu_addr;
                end
            end
            if (push_en) begin
                lq_valid[push_idx]      <= 1'b1;
                lq_addr_valid[push_idx] <= 1'b0;
                ldq_tracker[push_idx]   <= stq_deq ? stq_tail - 1'b1 : stq_tail;
                lq_op[push_idx]         <= mem_op_t'(disp_op);
                lq_rob_id[push_idx]     <= disp_rob_id;
                lq_rd[push_idx]         <= disp_rd;
            end
            if (ld_gnt) begin
                lq_valid[issue_idx] <= 1'b0;
            end
        end
    end

    always_comb begin
        valid_nxt = lq_valid;
        if (ld_gnt) valid_nxt[issue_idx] = 1'b0;
        if (push_en) valid_nxt[push_idx] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) ldq_ready <= 1'b0;
        else        ldq_ready <= flush || !(&valid_nxt);
    end

    assign ld_req  = issue_en;
    assign ld_addr = {ldq_addr[issue_idx][XLEN-1:2], 2'b00};
    assign ld_sel  = byte_sel(lq_op[issue_idx], ldq_addr[issue_idx][1:0]);
    assign ld_kill = flush;

    // response stage
    always_ff @(posedge clk) begin
        if (ld_gnt) begin
            rsp_op     <= lq_op[issue_idx];
            rsp_off    <= ldq_addr[issue_idx][1:0];
            res_rob_id <= lq_rob_id[issue_idx];
            res_rd     <= lq_rd[issue_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
            kill      <= 1'b0;
        end else begin
            if (ld_gnt)       in_flight <= 1'b1;
            else if (ld_resp) in_flight <= 1'b0;
            if (ld_resp)                 kill <= 1'b0;
            else if (flush && in_flight) kill <= 1'b1;  // load crossed a flush
        end
    end

    always_comb begin
        case (rsp_op)
            MEM_LB:  res_value = {{24{ld_rdata[8*rsp_off+7]}}, ld_rdata[8*rsp_off +: 8]};
            MEM_LBU: res_value = {24'b0, ld_rdata[8*rsp_off +: 8]};
            MEM_LH:  res_value = {{16{ld_rdata[16*rsp_off[1]+15]}}, ld_rdata[16*rsp_off[1] +: 16]};
            MEM_LHU: res_value = {16'b0, ld_rdata[16*rsp_off[1] +: 16]};
            default: res_value = ld_rdata;
        endcase
    end

    assign res_valid = ld_resp && !kill && !flush;

endmodule

// File: store_queue.sv
`timescale 1ns/100ps

module store_queue
    import lsu_cfg_pkg::*;
    import mem_op_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 commit,

    input  logic                 disp_valid,
    input  logic [3:0]           disp_op,
    input  logic [ROB_ID_W-1:0]  disp_rob_id,
    output logic                 stq_ready,

    input  logic                 agu_valid,
    input  logic [ROB_ID_W-1:0]  agu_rob_id,
    input  logic [XLEN-1:0]      agu_addr,
    input  logic [XLEN-1:0]      agu_wdata,

    output logic [STQ_IDX-1:0]   stq_tail,
    output logic                 stq_deq,
    output logic [LDQ_DEPTH-1:0] has_conflict,
    input  logic [STQ_IDX-1:0]   ldq_tracker [LDQ_DEPTH],
    input  logic [XLEN-1:0]      ldq_addr    [LDQ_DEPTH],

    output logic                 st_req,
    output logic [XLEN-1:0]      st_addr,
    output logic [3:0]           st_sel,
    output logic [XLEN-1:0]      st_wdata,
    input  logic                 st_done
);
    logic [STQ_IDX-1:0]  head, tail, cmt;
    logic [STQ_IDX-1:0]  head_nxt, tail_nxt, cmt_nxt;
    logic [STQ_IDX-1:0]  count, count_nxt;
    logic [STQ_IDX-2:0]  hs;
    logic [STQ_IDX-2:0]  slot [STQ_DEPTH];   // j-th entry from head
    logic                push;

    logic                sq_addr_valid [STQ_DEPTH];
    logic [3:0]          sq_op     [STQ_DEPTH];
    logic [ROB_ID_W-1:0] sq_rob_id [STQ_DEPTH];
    logic [XLEN-1:0]     sq_addr   [STQ_DEPTH];
    logic [XLEN-1:0]     sq_data   [STQ_DEPTH];

    assign hs    = head[STQ_IDX-2:0];
    assign count = tail - head;
    assign push  = disp_valid && stq_ready && is_store(disp_op) && !flush;

    assign head_nxt  = head + STQ_IDX'(st_done);
    assign cmt_nxt   = cmt + STQ_IDX'(commit);
    assign tail_nxt  = flush ? cmt_nxt : tail + STQ_IDX'(push);  // drop uncommitted
    assign count_nxt = tail_nxt - head_nxt;

    assign stq_tail = count + STQ_IDX'(push);
    assign stq_deq  = st_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            cmt       <= '0;
            stq_ready <= 1'b0;
        end else begin
            head      <= head_nxt;
            tail      <= tail_nxt;
            cmt       <= cmt_nxt;
            stq_ready <= count_nxt != STQ_IDX'(STQ_DEPTH);
        end
    end

    always_comb begin
        for (int j = 0; j < STQ_DEPTH; j++) begin
            slot[j] = hs + (STQ_IDX-1)'(j);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            sq_addr_valid[tail[STQ_IDX-2:0]] <= 1'b0;
            sq_op[tail[STQ_IDX-2:0]]         <= disp_op;
            sq_rob_id[tail[STQ_IDX-2:0]]     <= disp_rob_id;
        end
        for (int j = 0; j < STQ_DEPTH; j++) begin
            if (agu_valid && STQ_IDX'(j) < count && sq_rob_id[slot[j]] == agu_rob_id) begin
                sq_addr_valid[slot[j]] <= 1'b1;
                sq_addr[slot[j]]       <= agu_addr;
                sq_data[slot[j]]       <= agu_wdata;
            end
        end
    end

    // head drains once committed
    assign st_req   = (head != cmt) && sq_addr_valid[hs];
    assign st_addr  = {sq_addr[hs][XLEN-1:2], 2'b00};
    assign st_sel   = byte_sel(sq_op[hs], sq_addr[hs][1:0]);
    assign st_wdata = sq_data[hs] << {sq_addr[hs][1:0], 3'b000};

    // unknown or same-word older store blocks the load
    always_comb begin
        for (int i = 0; i < LDQ_DEPTH; i++) begin
            has_conflict[i] = 1'b0;
            for (int j = 0; j < STQ_DEPTH; j++) begin
                if (STQ_IDX'(j) < ldq_tracker[i] && (!sq_addr_valid[slot[j]] ||
                    sq_addr[slot[j]][XLEN-1:2] == ldq_addr[i][XLEN-1:2])) begin
                    has_conflict[i] = 1'b1;
                end
            end
        end
    end

endmodule

// File: mem_port_arb.sv
`timescale 1ns/100ps

module mem_port_arb
    import lsu_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            ld_req,
    input  logic [XLEN-1:0] ld_addr,
    input  logic [3:0]      ld_sel,
    input  logic            ld_kill,
    output logic            ld_gnt,
    output logic            ld_resp,
    output logic [XLEN-1:0] ld_rdata,

    input  logic            st_req,
    input  logic [XLEN-1:0] st_addr,
    input  logic [3:0]      st_sel,
    input  logic [XLEN-1:0] st_wdata,
    output logic            st_done,

    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output logic [XLEN-1:0] wb_adr,
    output logic [3:0]      wb_sel,
    output logic [XLEN-1:0] wb_dat_o,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic            wb_ack
);
    typedef enum logic {IDLE, BUSY} arb_state_t;

    arb_state_t state;
    logic       is_load;

    // committed store first, no load issue in a flush cycle
    assign ld_gnt  = state == IDLE && ld_req && !st_req && !ld_kill;
    assign st_done = state == BUSY && !is_load && wb_ack;
    assign wb_cyc  = state == BUSY;
    assign wb_stb  = wb_cyc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            ld_resp <= 1'b0;
        end else begin
            ld_resp <= state == BUSY && is_load && wb_ack;
            case (state)
                IDLE:    if (st_req || ld_gnt) state <= BUSY;
                default: if (wb_ack) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (st_req) begin
                is_load  <= 1'b0;
                wb_we    <= 1'b1;
                wb_adr   <= st_addr;
                wb_sel   <= st_sel;
                wb_dat_o <= st_wdata;
            end else if (ld_gnt) begin
                is_load <= 1'b1;
                wb_we   <= 1'b0;
                wb_adr  <= ld_addr;
                wb_sel  <= ld_sel;
            end
        end
        if (state == BUSY && is_load && wb_ack) ld_rdata <= wb_dat_i;
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/100ps

module lsu_top
    import lsu_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                commit,

    input  logic                disp_valid,
    input  logic [3:0]          disp_op,
    input  logic [ROB_ID_W-1:0] disp_rob_id,
    input  logic [RD_W-1:0]     disp_rd,
    output logic                disp_ready,

    input  logic                agu_valid,
    input  logic [ROB_ID_W-1:0] agu_rob_id,
    input  logic [XLEN-1:0]     agu_addr,
    input  logic [XLEN-1:0]     agu_wdata,

    output logic                res_valid,
    output logic [ROB_ID_W-1:0] res_rob_id,
    output logic [RD_W-1:0]     res_rd,
    output logic [XLEN-1:0]     res_value,

    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output logic [XLEN-1:0]     wb_adr,
    output logic [3:0]          wb_sel,
    output logic [XLEN-1:0]     wb_dat_o,
    input  logic [XLEN-1:0]     wb_dat_i,
    input  logic                wb_ack
);
    logic                 ldq_ready, stq_ready;
    logic [STQ_IDX-1:0]   stq_tail;
    logic                 stq_deq;
    logic [LDQ_DEPTH-1:0] has_conflict;
    logic [STQ_IDX-1:0]   ldq_tracker [LDQ_DEPTH];
    logic [XLEN-1:0]      ldq_addr    [LDQ_DEPTH];

    logic                 ld_req, ld_kill, ld_gnt, ld_resp;
    logic [XLEN-1:0]      ld_addr, ld_rdata;
    logic [3:0]           ld_sel;
    logic                 st_req, st_done;
    logic [XLEN-1:0]      st_addr, st_wdata;
    logic [3:0]           st_sel;

    assign disp_ready = disp_op[3] ? stq_ready : ldq_ready;  // top bit marks a store

    load_queue u_ldq (
        .clk, .rst_n, .flush,
        .disp_valid, .disp_op, .disp_rob_id, .disp_rd, .ldq_ready,
        .agu_valid, .agu_rob_id, .agu_addr,
        .stq_tail, .stq_deq, .has_conflict, .ldq_tracker, .ldq_addr,
        .ld_req, .ld_addr, .ld_sel, .ld_kill, .ld_gnt, .ld_resp, .ld_rdata,
        .res_valid, .res_rob_id, .res_rd, .res_value
    );

    store_queue u_stq (
        .clk, .rst_n, .flush, .commit,
        .disp_valid, .disp_op, .disp_rob_id, .stq_ready,
        .agu_valid, .agu_rob_id, .agu_addr, .agu_wdata,
        .stq_tail, .stq_deq, .has_conflict, .ldq_tracker, .ldq_addr,
        .st_req, .st_addr, .st_sel, .st_wdata, .st_done
    );

    mem_port_arb u_arb (
        .clk, .rst_n,
        .ld_req, .ld_addr, .ld_sel, .ld_kill, .ld_gnt, .ld_resp, .ld_rdata,
        .st_req, .st_addr, .st_sel, .st_wdata, .st_done,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_o, .wb_dat_i, .wb_ack
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real PERIOD     = 20.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    initial clk = 1'b0;
    always #(PERIOD / 2.0) clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;   // release just after the edge
    end

endmodule

// File: tb_wb_mem.sv
`timescale 1ns/100ps

module tb_wb_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [3:0]  sel,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack
);
    logic [31:0] mem [64];
    logic [1:0]  wait_cnt;
    logic [31:0] rnd;
    integer      seed;

    initial begin
        seed = 32'he65c4616;
        for (int i = 0; i < 64; i++) begin
            mem[i] = (32'h9e3779b9 * 32'(i + 1)) ^ (32'(i) << 20);
        end
        rnd      = $random(seed);
        wait_cnt = rnd[1:0];
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (wait_cnt == 2'd0) begin
                    ack <= 1'b1;
                    if (we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) mem[adr[7:2]][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end else begin
                        dat_o <= mem[adr[7:2]];
                    end
                    rnd      = $random(seed);
                    wait_cnt <= rnd[1:0];   // next delay 0..3
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

// File: tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu
    import lsu_cfg_pkg::*;
    import mem_op_pkg::*;
();
    localparam int K_DISP   = 0;
    localparam int K_ADDR   = 1;
    localparam int K_CMT    = 2;
    localparam int K_FLUSH  = 3;
    localparam int K_RESULT = 4;
    localparam int K_READY  = 5;
    localparam int K_QUIET  = 6;

    localparam int HOLD_CYCLES = 8;   // longer than an unblocked load takes

    logic clk, rst_n, flush, commit;
    logic disp_valid, disp_ready, agu_valid, res_valid;
    logic [3:0] disp_op;
    logic [ROB_ID_W-1:0] disp_rob_id, agu_rob_id, res_rob_id;
    logic [RD_W-1:0] disp_rd, res_rd;
    logic [XLEN-1:0] agu_addr, agu_wdata, res_value;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [XLEN-1:0] wb_adr, wb_dat_o, wb_dat_i;
    logic [3:0] wb_sel;

    // stimulus table
    int          r_kind [$];
    logic [3:0]  r_op   [$];
    int          r_rob  [$];
    logic [31:0] r_addr [$];
    logic [31:0] r_data [$];
    logic [31:0] r_exp  [$];
    string       r_name [$];

    // stores seen by the testbench, in program order
    int          st_rob  [$];
    logic [3:0]  st_op   [$];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    int          cmt_cnt;

    logic [7:0]  ref_mem [256];
    logic        outstanding [32];
    logic        got [32];
    logic [31:0] got_value [32];
    logic [RD_W-1:0] got_rd [32];
    int          errors, tests;

    tb_clk_gen #(.PERIOD(20.0), .RST_CYCLES(4)) u_clk (.clk, .rst_n);

    tb_wb_mem u_mem (
        .clk, .rst_n, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .sel(wb_sel), .dat_i(wb_dat_o), .dat_o(wb_dat_i), .ack(wb_ack)
    );

    lsu_top uut (.*);

    task automatic add_row(input int k, input logic [3:0] op, input int rob,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input string name);
        r_kind.push_back(k);
        r_op.push_back(op);
        r_rob.push_back(rob);
        r_addr.push_back(addr);
        r_data.push_back(data);
        r_exp.push_back(exp);
        r_name.push_back(name);
    endtask

    // dispatch, address and result check of one load
    task automatic add_load(input logic [3:0] op, input int rob, input logic [31:0] addr,
                            input string name);
        add_row(K_DISP, op, rob, 0, 0, 0, name);
        add_row(K_ADDR, op, rob, addr, 0, 0, name);
        add_row(K_RESULT, op, rob, addr, 0, 0, name);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // destination register kept apart from the ROB id
    function automatic logic [RD_W-1:0] dest_reg(input int rob);
        return RD_W'(rob + 32);
    endfunction

    function automatic logic [31:0] expect_load(input logic [3:0] op, input logic [31:0] addr);
        logic [31:0] v;
        int n;
        n = 1 << op[1:0];
        v = '0;
        for (int b = 0; b < n; b++) v[8*b +: 8] = ref_mem[(int'(addr[7:0]) + b) & 255];
        if (!op[2] && n == 1) v = {{24{v[7]}}, v[7:0]};
        if (!op[2] && n == 2) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    task automatic apply_commit();
        int n;
        n = 1 << st_op[cmt_cnt][1:0];
        for (int b = 0; b < n; b++) begin
            ref_mem[(int'(st_addr[cmt_cnt][7:0]) + b) & 255] = st_data[cmt_cnt][8*b +: 8];
        end
        cmt_cnt++;
    endtask

    task automatic build_table();
        add_row(K_DISP, MEM_SW, 1, 0, 0, 0, "alias_store");
        add_row(K_DISP, MEM_LW, 2, 0, 0, 0, "alias_load");
        add_row(K_ADDR, MEM_LW, 2, 32'h40, 0, 0, "alias_load_addr");
        add_row(K_ADDR, MEM_SW, 1, 32'h40, 32'h80ff7f01, 0, "alias_store_addr");
        add_row(K_CMT, MEM_SW, 1, 0, 0, 0, "alias_commit");
        add_row(K_RESULT, MEM_LW, 2, 32'h40, 0, 0, "alias_result");
        add_row(K_DISP, MEM_SW, 3, 0, 0, 0, "late_store");
        add_row(K_DISP, MEM_LB, 4, 0, 0, 0, "early_load");
        add_row(K_ADDR, MEM_LB, 4, 32'h80, 0, 0, "early_load_addr");
        add_row(K_QUIET, MEM_LB, 4, 0, 0, 0, "early_load_held");
        add_row(K_ADDR, MEM_SW, 3, 32'h84, 32'h5a5a0000, 0, "late_store_addr");
        add_row(K_RESULT, MEM_LB, 4, 32'h80, 0, 0, "early_load");
        add_row(K_CMT, MEM_SW, 3, 0, 0, 0, "late_commit");
        for (int i = 0; i < 4; i++) begin
            add_load(MEM_LB, 5 + i, 32'h40 + i, $sformatf("lb_off%0d", i));
            add_load(MEM_LBU, 9 + i, 32'h40 + i, $sformatf("lbu_off%0d", i));
        end
        for (int i = 0; i < 2; i++) begin
            add_load(MEM_LH, 13 + i, 32'h40 + 2 * i, $sformatf("lh_off%0d", 2 * i));
            add_load(MEM_LHU, 15 + i, 32'h40 + 2 * i, $sformatf("lhu_off%0d", 2 * i));
        end
        add_load(MEM_LW, 17, 32'h44, "lw_full");
        add_row(K_DISP, MEM_SW, 18, 0, 0, 0, "flush_kept_store");
        add_row(K_DISP, MEM_SW, 19, 0, 0, 0, "flush_lost_store");
        add_row(K_DISP, MEM_LW, 20, 0, 0, 0, "flush_lost_load");
        add_row(K_ADDR, MEM_SW, 19, 32'h68, 32'h0badf00d, 0, "flush_lost_store_addr");
        add_row(K_ADDR, MEM_LW, 20, 32'h60, 0, 0, "flush_lost_load_addr");  // waits on store 18
        add_row(K_ADDR, MEM_SW, 18, 32'h60, 32'h1234abcd, 0, "flush_store_addr");
        add_row(K_CMT, MEM_SW, 18, 0, 0, 0, "flush_commit");
        add_row(K_FLUSH, MEM_LW, 0, 0, 0, 0, "flush");
        add_load(MEM_LW, 21, 32'h60, "after_flush");
        for (int i = 0; i < 4; i++) add_row(K_DISP, MEM_LW, 22 + i, 0, 0, 0, "fill");
        add_row(K_READY, MEM_LW, 0, 0, 0, 0, "ldq_full");
        for (int i = 0; i < 4; i++) begin
            add_row(K_ADDR, MEM_LW, 22 + i, 32'(4 * i), 0, 0, "fill_addr");
            add_row(K_RESULT, MEM_LW, 22 + i, 32'(4 * i), 0, 0, $sformatf("fill_load%0d", i));
            if (i == 0) add_row(K_READY, MEM_LW, 0, 0, 0, 1, "ldq_free");
        end
    endtask

    // results are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            if (!outstanding[res_rob_id]) begin
                $display("unexpected result for ROB id %0d", res_rob_id);
                errors++;
            end else begin
                outstanding[res_rob_id] = 1'b0;
                got[res_rob_id]         = 1'b1;
                got_value[res_rob_id]   = res_value;
                got_rd[res_rob_id]      = res_rd;
            end
        end
    end

    initial begin
        @(posedge rst_n);
        repeat (r_kind.size() * 40) @(posedge clk);
        $display("timeout: the run hung waiting on the DUT");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int e0;
        flush = 1'b0;
        commit = 1'b0;
        disp_valid = 1'b0;
        disp_op = MEM_LW;
        disp_rob_id = '0;
        disp_rd = '0;
        agu_valid = 1'b0;
        agu_rob_id = '0;
        agu_addr = '0;
        agu_wdata = '0;
        errors = 0;
        tests = 0;
        cmt_cnt = 0;
        for (int i = 0; i < 32; i++) begin
            outstanding[i] = 1'b0;
            got[i] = 1'b0;
        end
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = 8'(((32'h9e3779b9 * 32'(a / 4 + 1)) ^ (32'(a / 4) << 20)) >> (8 * (a % 4)));
        end
        build_table();
        @(posedge rst_n);
        @(posedge clk);
        #2;
        for (int r = 0; r < r_kind.size(); r++) begin
            e0 = errors;
            case (r_kind[r])
                K_DISP: begin
                    disp_valid = 1'b1;
                    disp_op = r_op[r];
                    disp_rob_id = ROB_ID_W'(r_rob[r]);
                    disp_rd = dest_reg(r_rob[r]);
                    @(negedge clk);
                    while (!disp_ready) @(negedge clk);
                    @(posedge clk);
                    #2 disp_valid = 1'b0;
                    if (is_store(r_op[r])) begin
                        st_rob.push_back(r_rob[r]);
                        st_op.push_back(r_op[r]);
                        st_addr.push_back(0);
                        st_data.push_back(0);
                    end else begin
                        outstanding[r_rob[r]] = 1'b1;
                        got[r_rob[r]] = 1'b0;
                    end
                end
                K_ADDR: begin
                    agu_valid = 1'b1;
                    agu_rob_id = ROB_ID_W'(r_rob[r]);
                    agu_addr = r_addr[r];
                    agu_wdata = r_data[r];
                    @(posedge clk);
                    #2 agu_valid = 1'b0;
                    foreach (st_rob[i]) begin
                        if (st_rob[i] == r_rob[r]) begin
                            st_addr[i] = r_addr[r];
                            st_data[i] = r_data[r];
                        end
                    end
                end
                K_CMT: begin
                    commit = 1'b1;
                    @(posedge clk);
                    #2 commit = 1'b0;
                    apply_commit();
                end
                K_FLUSH: begin
                    flush = 1'b1;
                    @(posedge clk);
                    #2 flush = 1'b0;
                    for (int i = 0; i < 32; i++) outstanding[i] = 1'b0;
                    while (st_rob.size() > cmt_cnt) begin
                        void'(st_rob.pop_back());
                        void'(st_op.pop_back());
                        void'(st_addr.pop_back());
                        void'(st_data.pop_back());
                    end
                end
                K_RESULT: begin
                    while (!got[r_rob[r]]) @(negedge clk);
                    compare(r_name[r], expect_load(r_op[r], r_addr[r]), got_value[r_rob[r]]);
                    compare($sformatf("%s rd", r_name[r]), 32'(dest_reg(r_rob[r])),
                            32'(got_rd[r_rob[r]]));
                    @(posedge clk);
                    #2;
                end
                K_QUIET: begin
                    repeat (HOLD_CYCLES) @(posedge clk);
                    #2;
                    compare(r_name[r], r_exp[r], {31'b0, got[r_rob[r]]});
                end
                default: begin
                    disp_op = MEM_LW;
                    @(negedge clk);
                    compare(r_name[r], r_exp[r], {31'b0, disp_ready});
                    @(posedge clk);
                    #2;
                end
            endcase
            if (r_kind[r] == K_RESULT || r_kind[r] == K_READY || r_kind[r] == K_QUIET) begin
                tests++;
                $display("%s: %s", r_name[r], (e0 == errors) ? "ok" : "failed");
            end
        end
        repeat (10) @(posedge clk);
        for (int i = 0; i < 32; i++) begin
            if (outstanding[i]) begin
                $display("load with ROB id %0d never returned a result", i);
                errors++;
            end
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: lsu_top.f
lsu_cfg_pkg.sv
mem_op_pkg.sv
load_queue.sv
store_queue.sv
mem_port_arb.sv
lsu_top.sv
tb_clk_gen.sv
tb_wb_mem.sv
tb_lsu.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_lsu
FLIST = lsu_top.f
LOG   = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
